/* Bender.yml */
package:
  name: muldiv_unit

sources:
  - files:
      - source/arith_types_pkg.sv
      - source/seq_ctrl_pkg.sv
      - source/add_sub_flag.sv
      - source/negate_arbiter.sv
      - source/divider_unsigned.sv
      - source/divider_signed.sv
      - source/multiplier_signed.sv
      - source/muldiv_unit.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/tb_muldiv_unit.sv

/* all.f */
source/arith_types_pkg.sv
source/seq_ctrl_pkg.sv
source/add_sub_flag.sv
source/negate_arbiter.sv
source/divider_unsigned.sv
source/divider_signed.sv
source/multiplier_signed.sv
source/muldiv_unit.sv
sim/clock_gen.sv
sim/tb_muldiv_unit.sv

/* sim/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half low
    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

/* sim/tb_muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_muldiv_unit;

    typedef arith_types_pkg::word_t word_t;

    // 31 operations in the run, rounded up
    localparam int num_ops = 32;
    localparam int op_cycles = 45;
    localparam int cycle_limit = num_ops * op_cycles * 2 + 200;
    localparam int wait_bound = 200;
    localparam word_t min_val = 32'h8000_0000;

    logic  clk;
    logic  rst;
    logic  div_start;
    word_t div_a;
    word_t div_b;
    logic  mul_start;
    word_t mul_a;
    word_t mul_b;
    word_t div_q;
    word_t div_r;
    logic  div_finish;
    word_t mul_lo;
    word_t mul_hi;
    logic  mul_finish;

    // model results and check enables, changed only on the falling edge
    word_t exp_q;
    word_t exp_r;
    word_t exp_lo;
    word_t exp_hi;
    word_t cur_a;
    word_t cur_b;
    logic  exp_div_fin;
    logic  exp_mul_fin;
    logic  chk_div_fin;
    logic  chk_mul_fin;
    logic  chk_div_val;
    logic  chk_mul_val;

    int     error_count = 0;
    int     test_errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycle_count = 0;
    integer seed = 32'h2580;

    clock_gen #(
        .period (100)
    ) u_clock_gen (
        .clk (clk)
    );

    muldiv_unit #(
        .div_first (1'b1)
    ) u_muldiv_unit (
        .clk        (clk),
        .rst        (rst),
        .div_start  (div_start),
        .div_a      (div_a),
        .div_b      (div_b),
        .mul_start  (mul_start),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .div_q      (div_q),
        .div_r      (div_r),
        .div_finish (div_finish),
        .mul_lo     (mul_lo),
        .mul_hi     (mul_hi),
        .mul_finish (mul_finish)
    );

    a_div_fin: assert property (@(posedge clk) chk_div_fin |-> div_finish == exp_div_fin)
        else begin
            error_count++;
            $display("MISMATCH t=%0t div_finish expected %b actual %b",
                     $time, exp_div_fin, $sampled(div_finish));
        end

    a_mul_fin: assert property (@(posedge clk) chk_mul_fin |-> mul_finish == exp_mul_fin)
        else begin
            error_count++;
            $display("MISMATCH t=%0t mul_finish expected %b actual %b",
                     $time, exp_mul_fin, $sampled(mul_finish));
        end

    a_div_q: assert property (@(posedge clk) chk_div_val |-> div_q == exp_q)
        else begin
            error_count++;
            $display("MISMATCH t=%0t div_q expected %h actual %h",
                     $time, exp_q, $sampled(div_q));
        end

    a_div_r: assert property (@(posedge clk) chk_div_val |-> div_r == exp_r)
        else begin
            error_count++;
            $display("MISMATCH t=%0t div_r expected %h actual %h",
                     $time, exp_r, $sampled(div_r));
        end

    // dividend = quotient * divisor + remainder, modulo 2^32
    a_div_identity: assert property (@(posedge clk)
        chk_div_val |-> div_q * cur_b + div_r == cur_a)
        else begin
            error_count++;
            $display("MISMATCH t=%0t div_q*div_b+div_r expected %h actual %h",
                     $time, cur_a, $sampled(div_q) * cur_b + $sampled(div_r));
        end

    a_mul_lo: assert property (@(posedge clk) chk_mul_val |-> mul_lo == exp_lo)
        else begin
            error_count++;
            $display("MISMATCH t=%0t mul_lo expected %h actual %h",
                     $time, exp_lo, $sampled(mul_lo));
        end

    a_mul_hi: assert property (@(posedge clk) chk_mul_val |-> mul_hi == exp_hi)
        else begin
            error_count++;
            $display("MISMATCH t=%0t mul_hi expected %h actual %h",
                     $time, exp_hi, $sampled(mul_hi));
        end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // truncating division, remainder follows the dividend
    task automatic div_model(input word_t a, input word_t b, output word_t q, output word_t r);
        word_t a_abs;
        a_abs = a[31] ? -a : a;
        if (b == 32'd0) begin
            q = a[31] ? -arith_types_pkg::word_ones : arith_types_pkg::word_ones;
            r = a[31] ? -a_abs : a_abs;
        end else if (a == min_val && b == 32'hffff_ffff) begin
            q = min_val;
            r = 32'd0;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
    endtask

    task automatic mul_model(input word_t a, input word_t b, output word_t lo, output word_t hi);
        logic [63:0] prod;
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        lo = prod[31:0];
        hi = prod[63:32];
    endtask

    task automatic launch(input bit do_div, input bit do_mul, input word_t da, input word_t db,
                          input word_t ma, input word_t mb);
        @(negedge clk);
        if (do_div) begin
            div_model(da, db, exp_q, exp_r);
            cur_a = da;
            cur_b = db;
            div_a = da;
            div_b = db;
            div_start = 1'b1;
        end
        if (do_mul) begin
            mul_model(ma, mb, exp_lo, exp_hi);
            mul_a = ma;
            mul_b = mb;
            mul_start = 1'b1;
        end
        @(negedge clk);
        div_start = 1'b0;
        mul_start = 1'b0;
        // the start pulse drops finish
        exp_div_fin = 1'b0;
        exp_mul_fin = 1'b0;
        chk_div_fin = do_div;
        chk_mul_fin = do_mul;
        @(negedge clk);
        chk_div_fin = 1'b0;
        chk_mul_fin = 1'b0;
    endtask

    task automatic wait_done(input bit w_div, input bit w_mul);
        int n;
        n = 0;
        while (!((!w_div || div_finish) && (!w_mul || mul_finish)) && n < wait_bound) begin
            @(negedge clk);
            n++;
        end
        if (n >= wait_bound) begin
            error_count++;
            $display("t=%0t: an operation did not finish within %0d cycles", $time, wait_bound);
        end
    endtask

    // results and finish must hold for a few cycles
    task automatic check_results(input bit w_div, input bit w_mul);
        exp_div_fin = 1'b1;
        exp_mul_fin = 1'b1;
        chk_div_fin = w_div;
        chk_mul_fin = w_mul;
        chk_div_val = w_div;
        chk_mul_val = w_mul;
        repeat (3) @(negedge clk);
        chk_div_fin = 1'b0;
        chk_mul_fin = 1'b0;
        chk_div_val = 1'b0;
        chk_mul_val = 1'b0;
    endtask

    task automatic run_div(input word_t a, input word_t b);
        launch(1'b1, 1'b0, a, b, 32'd0, 32'd0);
        wait_done(1'b1, 1'b0);
        check_results(1'b1, 1'b0);
    endtask

    task automatic run_mul(input word_t a, input word_t b);
        launch(1'b0, 1'b1, 32'd0, 32'd0, a, b);
        wait_done(1'b0, 1'b1);
        check_results(1'b0, 1'b1);
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail, %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        word_t a;
        word_t b;
        rst = 1'b1;
        div_start = 1'b0;
        mul_start = 1'b0;
        div_a = 32'd0;
        div_b = 32'd0;
        mul_a = 32'd0;
        mul_b = 32'd0;
        exp_q = 32'd0;
        exp_r = 32'd0;
        exp_lo = 32'd0;
        exp_hi = 32'd0;
        cur_a = 32'd0;
        cur_b = 32'd0;
        exp_div_fin = 1'b0;
        exp_mul_fin = 1'b0;
        chk_div_fin = 1'b0;
        chk_mul_fin = 1'b0;
        chk_div_val = 1'b0;
        chk_mul_val = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // everything zero and idle after reset
        chk_div_fin = 1'b1;
        chk_mul_fin = 1'b1;
        chk_div_val = 1'b1;
        chk_mul_val = 1'b1;
        @(negedge clk);
        chk_div_fin = 1'b0;
        chk_mul_fin = 1'b0;
        chk_div_val = 1'b0;
        chk_mul_val = 1'b0;
        end_test("reset");

        run_div(32'd100, 32'd7);
        run_div(-32'd100, 32'd7);
        run_div(32'd100, -32'd7);
        run_div(-32'd100, -32'd7);
        for (int s = 0; s < 4; s++) begin
            a = rand_word() & 32'h7fff_ffff;
            b = (rand_word() & 32'h0000_ffff) | 32'd1;
            run_div(s[0] ? -a : a, s[1] ? -b : b);
        end
        end_test("divider signs");

        run_div(32'd12345, 32'd0);
        run_div(-32'd12345, 32'd0);
        run_div(min_val, 32'hffff_ffff);
        run_div(32'd0, -32'd5);
        end_test("divider corners");

        run_mul(min_val, min_val);
        run_mul(min_val, 32'hffff_ffff);
        run_mul(32'd0, -32'd5);
        run_mul(min_val, 32'd0);
        for (int i = 0; i < 4; i++) begin
            run_mul(rand_word(), rand_word());
        end
        end_test("multiplier");

        // both engines ask for the adder in the same cycle
        launch(1'b1, 1'b1, -32'd1000, -32'd13, -32'd123456, -32'd789);
        wait_done(1'b1, 1'b1);
        check_results(1'b1, 1'b1);
        launch(1'b1, 1'b1, -32'd7, 32'd3, 32'd5, -32'd9);
        wait_done(1'b1, 1'b1);
        check_results(1'b1, 1'b1);
        end_test("contention");

        // back to back, and a restart while busy
        run_div(32'd99, 32'd10);
        run_div(-32'd99, 32'd10);
        run_mul(32'd3, -32'd4);
        launch(1'b1, 1'b1, 32'd500, 32'd3, 32'd77, 32'd88);
        repeat (5) @(negedge clk);
        run_div(-32'd81, 32'd9);
        run_mul(-32'd6, 32'd7);
        end_test("finish behavior");

        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/add_sub_flag.sv */
`timescale 1ns/1ns
`default_nettype none

module add_sub_flag (
    input  wire arith_types_pkg::word_t a,
    input  wire arith_types_pkg::word_t b,
    input  wire                         carry_in,
    input  wire                         subtract,
    output arith_types_pkg::word_t      sum,
    output logic                        carry_flag,
    output logic                        overflow_flag,
    output logic                        zero_flag,
    output logic                        sign_flag
);

    arith_types_pkg::word_t b_eff;
    logic [32:0]            full_sum;

    // subtract is a + ~b + carry_in
    assign b_eff = subtract ? (b ^ arith_types_pkg::word_ones) : b;
    assign full_sum = {1'b0, a} + {1'b0, b_eff} + {32'b0, carry_in};

    assign sum = full_sum[31:0];
    assign carry_flag = full_sum[32];

    // same input signs but result sign differs
    assign overflow_flag = (a[31] == b_eff[31]) && (sum[31] != a[31]);
    assign zero_flag = (sum == arith_types_pkg::word_zero);
    assign sign_flag = sum[31];

endmodule

`default_nettype wire

/* source/arith_types_pkg.sv */
`default_nettype none

package arith_types_pkg;

    // one data word: operands, quotient, remainder, product halves
    typedef logic [31:0] word_t;

    // multiplier accumulator
    typedef logic [63:0] dword_t;

    // A input of the adder when it negates
    localparam word_t word_zero = 32'h0000_0000;

    // quotient magnitude for a zero divisor
    localparam word_t word_ones = 32'hffff_ffff;

endpackage

`default_nettype wire

/* source/divider_signed.sv */
`timescale 1ns/1ns
`default_nettype none

module divider_signed (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire arith_types_pkg::word_t a,
    input  wire arith_types_pkg::word_t b,
    input  wire                         neg_grant,
    input  wire arith_types_pkg::word_t neg_result,
    output arith_types_pkg::word_t      q,
    output arith_types_pkg::word_t      r,
    output logic                        finish,
    output logic                        neg_req,
    output arith_types_pkg::word_t      neg_operand,
    output logic                        neg_borrow
);

    seq_ctrl_pkg::div_state_t state;
    arith_types_pkg::word_t   a_mag;
    arith_types_pkg::word_t   b_mag;
    logic                     q_sign;
    logic                     r_sign;
    logic                     udiv_start;
    arith_types_pkg::word_t   udiv_q;
    arith_types_pkg::word_t   udiv_r;
    logic                     udiv_finish;

    divider_unsigned u_divider_unsigned (
        .clk       (clk),
        .rst       (rst),
        .start     (udiv_start),
        .dividend  (a_mag),
        .divisor   (b_mag),
        .quotient  (udiv_q),
        .remainder (udiv_r),
        .finish    (udiv_finish)
    );

    // plain negation, never a borrow
    assign neg_borrow = 1'b0;

    always_comb begin
        neg_req = 1'b0;
        neg_operand = a_mag;
        case (state)
            seq_ctrl_pkg::DIV_NEG_A: neg_req = a_mag[31];
            seq_ctrl_pkg::DIV_NEG_B: begin
                neg_req = b_mag[31];
                neg_operand = b_mag;
            end
            seq_ctrl_pkg::DIV_NEG_Q: begin
                neg_req = q_sign;
                neg_operand = q;
            end
            seq_ctrl_pkg::DIV_NEG_R: begin
                neg_req = r_sign;
                neg_operand = r;
            end
            default: neg_req = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_ctrl_pkg::DIV_IDLE;
            finish <= 1'b0;
            udiv_start <= 1'b0;
            q_sign <= 1'b0;
            r_sign <= 1'b0;
            q <= arith_types_pkg::word_zero;
            r <= arith_types_pkg::word_zero;
        end else begin
            udiv_start <= 1'b0;
            if (start) begin
                a_mag <= a;
                b_mag <= b;
                q_sign <= a[31] ^ b[31];
                // remainder follows the dividend
                r_sign <= a[31];
                finish <= 1'b0;
                state <= seq_ctrl_pkg::DIV_NEG_A;
            end else begin
                case (state)
                    seq_ctrl_pkg::DIV_NEG_A: begin
                        if (neg_grant) a_mag <= neg_result;
                        if (neg_grant || !a_mag[31]) state <= seq_ctrl_pkg::DIV_NEG_B;
                    end
                    seq_ctrl_pkg::DIV_NEG_B: begin
                        if (neg_grant) b_mag <= neg_result;
                        if (neg_grant || !b_mag[31]) begin
                            udiv_start <= 1'b1;
                            state <= seq_ctrl_pkg::DIV_RUN;
                        end
                    end
                    seq_ctrl_pkg::DIV_RUN: begin
                        // finish may still be high from the last run during the pulse
                        if (udiv_finish && !udiv_start) begin
                            q <= udiv_q;
                            r <= udiv_r;
                            state <= seq_ctrl_pkg::DIV_NEG_Q;
                        end
                    end
                    seq_ctrl_pkg::DIV_NEG_Q: begin
                        if (neg_grant) q <= neg_result;
                        if (neg_grant || !q_sign) state <= seq_ctrl_pkg::DIV_NEG_R;
                    end
                    seq_ctrl_pkg::DIV_NEG_R: begin
                        if (neg_grant) r <= neg_result;
                        if (neg_grant || !r_sign) begin
                            finish <= 1'b1;
                            state <= seq_ctrl_pkg::DIV_DONE;
                        end
                    end
                    default: state <= state;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/divider_unsigned.sv */
`timescale 1ns/1ns
`default_nettype none

module divider_unsigned (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire arith_types_pkg::word_t dividend,
    input  wire arith_types_pkg::word_t divisor,
    output arith_types_pkg::word_t      quotient,
    output arith_types_pkg::word_t      remainder,
    output logic                        finish
);

    seq_ctrl_pkg::udiv_state_t state;
    arith_types_pkg::word_t    quo;
    arith_types_pkg::word_t    rem;
    arith_types_pkg::word_t    dvs;
    logic [4:0]                step;
    logic [32:0]               shifted;
    logic [32:0]               trial;

    // partial remainder with the next dividend bit shifted in
    assign shifted = {rem, quo[31]};
    assign trial = shifted - {1'b0, dvs};

    assign quotient = quo;
    assign remainder = rem;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_ctrl_pkg::UDIV_IDLE;
            finish <= 1'b0;
            step <= 5'd0;
            quo <= arith_types_pkg::word_zero;
            rem <= arith_types_pkg::word_zero;
        end else if (start) begin
            // load cycle
            state <= seq_ctrl_pkg::UDIV_SHIFT;
            finish <= 1'b0;
            step <= 5'd0;
            quo <= dividend;
            rem <= arith_types_pkg::word_zero;
            dvs <= divisor;
        end else begin
            case (state)
                seq_ctrl_pkg::UDIV_SHIFT: begin
                    // no borrow means the divisor fits
                    if (!trial[32]) begin
                        rem <= trial[31:0];
                        quo <= {quo[30:0], 1'b1};
                    end else begin
                        rem <= shifted[31:0];
                        quo <= {quo[30:0], 1'b0};
                    end
                    step <= step + 5'd1;
                    if (step == 5'd31) begin
                        state <= seq_ctrl_pkg::UDIV_DONE;
                        finish <= 1'b1;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit #(
    parameter bit div_first = 1'b1
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         div_start,
    input  wire arith_types_pkg::word_t div_a,
    input  wire arith_types_pkg::word_t div_b,
    input  wire                         mul_start,
    input  wire arith_types_pkg::word_t mul_a,
    input  wire arith_types_pkg::word_t mul_b,
    output arith_types_pkg::word_t      div_q,
    output arith_types_pkg::word_t      div_r,
    output logic                        div_finish,
    output arith_types_pkg::word_t      mul_lo,
    output arith_types_pkg::word_t      mul_hi,
    output logic                        mul_finish
);

    logic                   div_neg_req;
    arith_types_pkg::word_t div_neg_operand;
    logic                   div_neg_borrow;
    logic                   div_neg_grant;
    logic                   mul_neg_req;
    arith_types_pkg::word_t mul_neg_operand;
    logic                   mul_neg_borrow;
    logic                   mul_neg_grant;
    arith_types_pkg::word_t neg_result;
    logic                   neg_carry;
    arith_types_pkg::word_t adder_b;
    logic                   adder_carry_in;
    arith_types_pkg::word_t adder_sum;
    logic                   adder_carry;

    divider_signed u_divider_signed (
        .clk         (clk),
        .rst         (rst),
        .start       (div_start),
        .a           (div_a),
        .b           (div_b),
        .neg_grant   (div_neg_grant),
        .neg_result  (neg_result),
        .q           (div_q),
        .r           (div_r),
        .finish      (div_finish),
        .neg_req     (div_neg_req),
        .neg_operand (div_neg_operand),
        .neg_borrow  (div_neg_borrow)
    );

    multiplier_signed u_multiplier_signed (
        .clk         (clk),
        .rst         (rst),
        .start       (mul_start),
        .a           (mul_a),
        .b           (mul_b),
        .neg_grant   (mul_neg_grant),
        .neg_result  (neg_result),
        .neg_carry   (neg_carry),
        .lo          (mul_lo),
        .hi          (mul_hi),
        .finish      (mul_finish),
        .neg_req     (mul_neg_req),
        .neg_operand (mul_neg_operand),
        .neg_borrow  (mul_neg_borrow)
    );

    negate_arbiter #(
        .div_first (div_first)
    ) u_negate_arbiter (
        .clk             (clk),
        .rst             (rst),
        .div_neg_req     (div_neg_req),
        .div_neg_operand (div_neg_operand),
        .div_neg_borrow  (div_neg_borrow),
        .mul_neg_req     (mul_neg_req),
        .mul_neg_operand (mul_neg_operand),
        .mul_neg_borrow  (mul_neg_borrow),
        .adder_sum       (adder_sum),
        .adder_carry     (adder_carry),
        .div_neg_grant   (div_neg_grant),
        .mul_neg_grant   (mul_neg_grant),
        .adder_b         (adder_b),
        .adder_carry_in  (adder_carry_in),
        .neg_result      (neg_result),
        .neg_carry       (neg_carry)
    );

    // shared negator, only the carry flag is needed
    add_sub_flag u_add_sub_flag (
        .a             (arith_types_pkg::word_zero),
        .b             (adder_b),
        .carry_in      (adder_carry_in),
        .subtract      (1'b1),
        .sum           (adder_sum),
        .carry_flag    (adder_carry),
        .overflow_flag (),
        .zero_flag     (),
        .sign_flag     ()
    );

endmodule

`default_nettype wire

/* source/multiplier_signed.sv */
`timescale 1ns/1ns
`default_nettype none

module multiplier_signed (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire arith_types_pkg::word_t a,
    input  wire arith_types_pkg::word_t b,
    input  wire                         neg_grant,
    input  wire arith_types_pkg::word_t neg_result,
    input  wire                         neg_carry,
    output arith_types_pkg::word_t      lo,
    output arith_types_pkg::word_t      hi,
    output logic                        finish,
    output logic                        neg_req,
    output arith_types_pkg::word_t      neg_operand,
    output logic                        neg_borrow
);

    seq_ctrl_pkg::mul_state_t state;
    arith_types_pkg::word_t   a_mag;
    arith_types_pkg::dword_t  acc;
    arith_types_pkg::dword_t  acc_next;
    logic [32:0]              partial;
    logic [4:0]               count;
    logic                     p_sign;
    logic                     lo_borrow;

    // b sits in the low half and shifts out as the upper half fills
    assign partial = acc[0] ? ({1'b0, acc[63:32]} + {1'b0, a_mag}) : {1'b0, acc[63:32]};
    assign acc_next = {partial, acc[31:1]};

    assign neg_borrow = (state == seq_ctrl_pkg::MUL_NEG_HI) ? lo_borrow : 1'b0;

    always_comb begin
        neg_req = 1'b0;
        neg_operand = a_mag;
        case (state)
            seq_ctrl_pkg::MUL_NEG_A: neg_req = a_mag[31];
            seq_ctrl_pkg::MUL_NEG_B: begin
                neg_req = acc[31];
                neg_operand = acc[31:0];
            end
            seq_ctrl_pkg::MUL_NEG_LO: begin
                neg_req = 1'b1;
                neg_operand = lo;
            end
            seq_ctrl_pkg::MUL_NEG_HI: begin
                neg_req = 1'b1;
                neg_operand = hi;
            end
            default: neg_req = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_ctrl_pkg::MUL_IDLE;
            finish <= 1'b0;
            count <= 5'd0;
            p_sign <= 1'b0;
            lo <= arith_types_pkg::word_zero;
            hi <= arith_types_pkg::word_zero;
        end else if (start) begin
            a_mag <= a;
            acc <= {arith_types_pkg::word_zero, b};
            p_sign <= a[31] ^ b[31];
            count <= 5'd0;
            finish <= 1'b0;
            state <= seq_ctrl_pkg::MUL_NEG_A;
        end else begin
            case (state)
                seq_ctrl_pkg::MUL_NEG_A: begin
                    if (neg_grant) a_mag <= neg_result;
                    if (neg_grant || !a_mag[31]) state <= seq_ctrl_pkg::MUL_NEG_B;
                end
                seq_ctrl_pkg::MUL_NEG_B: begin
                    if (neg_grant) acc[31:0] <= neg_result;
                    if (neg_grant || !acc[31]) state <= seq_ctrl_pkg::MUL_RUN;
                end
                seq_ctrl_pkg::MUL_RUN: begin
                    acc <= acc_next;
                    count <= count + 5'd1;
                    if (count == 5'd31) begin
                        lo <= acc_next[31:0];
                        hi <= acc_next[63:32];
                        if (p_sign) begin
                            state <= seq_ctrl_pkg::MUL_NEG_LO;
                        end else begin
                            finish <= 1'b1;
                            state <= seq_ctrl_pkg::MUL_DONE;
                        end
                    end
                end
                seq_ctrl_pkg::MUL_NEG_LO: begin
                    if (neg_grant) begin
                        lo <= neg_result;
                        // carry out of 0 - lo is set only when lo is zero
                        lo_borrow <= ~neg_carry;
                        state <= seq_ctrl_pkg::MUL_NEG_HI;
                    end
                end
                seq_ctrl_pkg::MUL_NEG_HI: begin
                    if (neg_grant) begin
                        hi <= neg_result;
                        finish <= 1'b1;
                        state <= seq_ctrl_pkg::MUL_DONE;
                    end
                end
                default: state <= state;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/negate_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module negate_arbiter #(
    parameter bit div_first = 1'b1
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         div_neg_req,
    input  wire arith_types_pkg::word_t div_neg_operand,
    input  wire                         div_neg_borrow,
    input  wire                         mul_neg_req,
    input  wire arith_types_pkg::word_t mul_neg_operand,
    input  wire                         mul_neg_borrow,
    input  wire arith_types_pkg::word_t adder_sum,
    input  wire                         adder_carry,
    output logic                        div_neg_grant,
    output logic                        mul_neg_grant,
    output arith_types_pkg::word_t      adder_b,
    output logic                        adder_carry_in,
    output arith_types_pkg::word_t      neg_result,
    output logic                        neg_carry
);

    localparam seq_ctrl_pkg::req_id_t default_owner =
        div_first ? seq_ctrl_pkg::REQ_DIV : seq_ctrl_pkg::REQ_MUL;

    // winner of the next tie, points at the last loser after a tie
    seq_ctrl_pkg::req_id_t prio;
    seq_ctrl_pkg::req_id_t owner;
    logic                  tie;

    assign tie = div_neg_req && mul_neg_req;

    always_comb begin
        if (tie) begin
            owner = prio;
        end else if (mul_neg_req) begin
            owner = seq_ctrl_pkg::REQ_MUL;
        end else begin
            owner = seq_ctrl_pkg::REQ_DIV;
        end
    end

    assign div_neg_grant = div_neg_req && (owner == seq_ctrl_pkg::REQ_DIV);
    assign mul_neg_grant = mul_neg_req && (owner == seq_ctrl_pkg::REQ_MUL);

    // adder computes 0 - operand - borrow
    assign adder_b = (owner == seq_ctrl_pkg::REQ_MUL) ? mul_neg_operand : div_neg_operand;
    assign adder_carry_in = (owner == seq_ctrl_pkg::REQ_MUL) ? ~mul_neg_borrow : ~div_neg_borrow;

    assign neg_result = adder_sum;
    assign neg_carry = adder_carry;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= default_owner;
        end else if (tie) begin
            prio <= ~owner;
        end else if (div_neg_req || mul_neg_req) begin
            // loser served once, back to the fixed order
            prio <= default_owner;
        end
    end

endmodule

`default_nettype wire

/* source/seq_ctrl_pkg.sv */
`default_nettype none

package seq_ctrl_pkg;

    // signed divider FSM
    typedef enum logic [2:0] {
        DIV_IDLE, DIV_NEG_A, DIV_NEG_B, DIV_RUN, DIV_NEG_Q, DIV_NEG_R, DIV_DONE
    } div_state_t;

    // signed multiplier FSM
    typedef enum logic [2:0] {
        MUL_IDLE, MUL_NEG_A, MUL_NEG_B, MUL_RUN, MUL_NEG_LO, MUL_NEG_HI, MUL_DONE
    } mul_state_t;

    // unsigned restoring divider FSM
    typedef enum logic [1:0] {
        UDIV_IDLE, UDIV_SHIFT, UDIV_DONE
    } udiv_state_t;

    // owner of the shared adder
    typedef logic req_id_t;

    localparam req_id_t REQ_DIV = 1'b0;
    localparam req_id_t REQ_MUL = 1'b1;

endpackage

`default_nettype wire
